/* hdl/ctl_delay_defines.svh */
`ifndef CTL_DELAY_DEFINES_SVH
`define CTL_DELAY_DEFINES_SVH

// Control lanes and lane index width
`define CTL_LANES     3
`define CTL_LANE_W    2

// Phaser-out tap counter widths
`define FINE_TAP_W    6
`define COARSE_TAP_W  3

`define FINE_TAP_INIT 40
`define SETTLE_CYCLES 8

`endif

/* hdl/ctl_delay_pkg.sv */
`default_nettype none
`include "ctl_delay_defines.svh"

package ctl_delay_pkg;

   typedef logic [`CTL_LANE_W-1:0]   lane_idx_t;
   typedef logic [`FINE_TAP_W-1:0]   fine_tap_t;
   typedef logic [`COARSE_TAP_W-1:0] coarse_tap_t;

   typedef enum logic [2:0] {
      IDLE,
      COARSE,
      FINE,
      NEXT_LANE,
      DONE
   } seq_state_t;

endpackage

`default_nettype wire

/* hdl/ctl_lane_delay_seq.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ctl_delay_defines.svh"

module ctl_lane_delay_seq
   import ctl_delay_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      start,
   input  wire fine_tap_t dec_taps,
   input  wire logic      coarse_inc,
   output lane_idx_t      lane_cnt,
   output logic           fine_en,
   output logic           coarse_en,
   output logic           done
);

   localparam int SETTLE_W = $clog2(`SETTLE_CYCLES);
   localparam logic [SETTLE_W-1:0] SETTLE_LOAD = SETTLE_W'(`SETTLE_CYCLES - 1);
   localparam lane_idx_t LAST_LANE = lane_idx_t'(`CTL_LANES - 1);

   seq_state_t          state;
   logic [SETTLE_W-1:0] settle_cnt;
   fine_tap_t           dec_left;
   logic                settle_over;
   logic [3:0]          done_dly;

   // Wait has run its full length when the counter reaches zero
   assign settle_over = (settle_cnt == '0);

   always_ff @(posedge clk) begin
      if (rst || !start) begin
         state      <= IDLE;
         lane_cnt   <= '0;
         fine_en    <= 1'b0;
         coarse_en  <= 1'b0;
         settle_cnt <= SETTLE_LOAD;
         dec_left   <= '0;
      end else begin
         // Strobes last one cycle
         fine_en   <= 1'b0;
         coarse_en <= 1'b0;

         case (state)
            IDLE: begin
               // First lane entry, dec_taps sampled here
               dec_left   <= dec_taps;
               settle_cnt <= SETTLE_LOAD;
               state      <= coarse_inc ? COARSE : FINE;
            end

            COARSE: begin
               if (settle_over) begin
                  coarse_en  <= 1'b1;
                  settle_cnt <= SETTLE_LOAD;
                  state      <= FINE;
               end else begin
                  settle_cnt <= settle_cnt - 1'b1;
               end
            end

            FINE: begin
               if (dec_left == '0) begin
                  state <= NEXT_LANE;
               end else if (settle_over) begin
                  fine_en    <= 1'b1;
                  dec_left   <= dec_left - 1'b1;
                  settle_cnt <= SETTLE_LOAD;
               end else begin
                  settle_cnt <= settle_cnt - 1'b1;
               end
            end

            NEXT_LANE: begin
               if (lane_cnt == LAST_LANE) begin
                  state <= DONE;
               end else begin
                  lane_cnt   <= lane_cnt + 1'b1;
                  dec_left   <= dec_taps;
                  settle_cnt <= SETTLE_LOAD;
                  state      <= coarse_inc ? COARSE : FINE;
               end
            end

            // Hold until start falls
            DONE: begin
               state <= DONE;
            end

            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Four-stage done delay, flushed as soon as start drops
   always_ff @(posedge clk) begin
      if (rst || !start) begin
         done_dly <= '0;
      end else begin
         done_dly <= {done_dly[2:0], state == DONE};
      end
   end

   assign done = done_dly[3];

   a_strobe_excl: assert property (
      @(posedge clk) disable iff (rst)
      !(fine_en && coarse_en)
   );

   a_lane_range: assert property (
      @(posedge clk) disable iff (rst)
      lane_cnt <= LAST_LANE
   );

   // Every strobe is followed by a full settle gap
   a_strobe_gap: assert property (
      @(posedge clk) disable iff (rst)
      (fine_en || coarse_en) |=> !(fine_en || coarse_en) [* `SETTLE_CYCLES - 1]
   );

endmodule

`default_nettype wire

/* hdl/phaser_out_lane.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ctl_delay_defines.svh"

module phaser_out_lane
   import ctl_delay_pkg::*;
#(
   parameter int LANE = 0
) (
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire lane_idx_t lane_cnt,
   input  wire logic      fine_en,
   input  wire logic      coarse_en,
   output fine_tap_t      fine_tap,
   output coarse_tap_t    coarse_tap,
   output logic           underflow_pulse
);

   localparam lane_idx_t MY_LANE   = lane_idx_t'(LANE);
   localparam fine_tap_t FINE_INIT = fine_tap_t'(`FINE_TAP_INIT);

   logic selected;

   assign selected = (lane_cnt == MY_LANE);

   // Fine stage counts down and sticks at zero
   always_ff @(posedge clk) begin
      if (rst) begin
         fine_tap        <= FINE_INIT;
         underflow_pulse <= 1'b0;
      end else begin
         underflow_pulse <= 1'b0;
         if (selected && fine_en) begin
            if (fine_tap == '0) begin
               underflow_pulse <= 1'b1;
            end else begin
               fine_tap <= fine_tap - 1'b1;
            end
         end
      end
   end

   // Coarse stage wraps
   always_ff @(posedge clk) begin
      if (rst) begin
         coarse_tap <= '0;
      end else if (selected && coarse_en) begin
         coarse_tap <= coarse_tap + 1'b1;
      end
   end

   // Strobes meant for other lanes must leave this one alone
   a_unselected_hold: assert property (
      @(posedge clk) disable iff (rst)
      !selected |=> ($stable(fine_tap) && $stable(coarse_tap))
   );

endmodule

`default_nettype wire

/* hdl/lane_tap_status.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ctl_delay_defines.svh"

module lane_tap_status
   import ctl_delay_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire fine_tap_t             fine_taps [`CTL_LANES],
   input  wire coarse_tap_t           coarse_taps [`CTL_LANES],
   input  wire logic [`CTL_LANES-1:0] underflow_pulses,
   input  wire lane_idx_t             rd_lane,
   output fine_tap_t                  rd_fine,
   output coarse_tap_t                rd_coarse,
   output logic                       rd_underflow,
   output logic                       any_underflow
);

   logic [`CTL_LANES-1:0] uf_sticky;

   // Sticky per lane, only reset clears it
   always_ff @(posedge clk) begin
      if (rst) begin
         uf_sticky <= '0;
      end else begin
         uf_sticky <= uf_sticky | underflow_pulses;
      end
   end

   assign any_underflow = |uf_sticky;

   // Readback mux, an index past the last lane reads zero
   always_comb begin
      rd_fine      = '0;
      rd_coarse    = '0;
      rd_underflow = 1'b0;
      for (int i = 0; i < `CTL_LANES; i++) begin
         if (rd_lane == lane_idx_t'(i)) begin
            rd_fine      = fine_taps[i];
            rd_coarse    = coarse_taps[i];
            rd_underflow = uf_sticky[i];
         end
      end
   end

   // A lane can only report underflow once its tap sits at zero
   for (genvar g = 0; g < `CTL_LANES; g++) begin : g_uf_chk
      a_flag_tap_zero: assert property (
         @(posedge clk) disable iff (rst)
         underflow_pulses[g] |-> (fine_taps[g] == '0)
      );
   end

endmodule

`default_nettype wire

/* hdl/ctl_delay_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ctl_delay_defines.svh"

module ctl_delay_top (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     start,
   input  wire logic [`FINE_TAP_W-1:0]   dec_taps,
   input  wire logic                     coarse_inc,
   input  wire logic [`CTL_LANE_W-1:0]   rd_lane,
   output wire logic [`CTL_LANE_W-1:0]   lane_cnt,
   output wire logic                     done,
   output wire logic [`FINE_TAP_W-1:0]   rd_fine,
   output wire logic [`COARSE_TAP_W-1:0] rd_coarse,
   output wire logic                     rd_underflow,
   output wire logic                     any_underflow
);

   wire logic                     fine_en;
   wire logic                     coarse_en;
   wire logic [`FINE_TAP_W-1:0]   fine_taps   [`CTL_LANES];
   wire logic [`COARSE_TAP_W-1:0] coarse_taps [`CTL_LANES];
   wire logic [`CTL_LANES-1:0]    underflow_pulses;

   ctl_lane_delay_seq ctl_lane_delay_seq_i (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .dec_taps   (dec_taps),
      .coarse_inc (coarse_inc),
      .lane_cnt   (lane_cnt),
      .fine_en    (fine_en),
      .coarse_en  (coarse_en),
      .done       (done)
   );

   // Every lane sees the same strobes and picks out its own index
   for (genvar i = 0; i < `CTL_LANES; i++) begin : g_lane
      phaser_out_lane #(
         .LANE (i)
      ) phaser_out_lane_i (
         .clk             (clk),
         .rst             (rst),
         .lane_cnt        (lane_cnt),
         .fine_en         (fine_en),
         .coarse_en       (coarse_en),
         .fine_tap        (fine_taps[i]),
         .coarse_tap      (coarse_taps[i]),
         .underflow_pulse (underflow_pulses[i])
      );
   end

   lane_tap_status lane_tap_status_i (
      .clk              (clk),
      .rst              (rst),
      .fine_taps        (fine_taps),
      .coarse_taps      (coarse_taps),
      .underflow_pulses (underflow_pulses),
      .rd_lane          (rd_lane),
      .rd_fine          (rd_fine),
      .rd_coarse        (rd_coarse),
      .rd_underflow     (rd_underflow),
      .any_underflow    (any_underflow)
   );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

/* test/ctl_delay_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ctl_delay_defines.svh"

module ctl_delay_tb
   import ctl_delay_pkg::*;
();

   localparam int CLK_NS     = 8;
   localparam int NUM_LANES  = `CTL_LANES;
   localparam int COARSE_MOD = 1 << `COARSE_TAP_W;
   // Worst case: every lane takes a coarse strobe and 64 fine strobes
   localparam int RUN_CYCLES = `CTL_LANES * (64 + 1) * (`SETTLE_CYCLES + 2);
   localparam int MAX_RUNS   = 14;
   localparam int WATCHDOG_CYCLES = MAX_RUNS * (RUN_CYCLES + 40) + 2000;

   logic        clk;
   logic        rst;
   logic        start;
   fine_tap_t   dec_taps;
   logic        coarse_inc;
   lane_idx_t   rd_lane;
   lane_idx_t   lane_cnt;
   logic        done;
   fine_tap_t   rd_fine;
   coarse_tap_t rd_coarse;
   logic        rd_underflow;
   logic        any_underflow;

   logic [31:0] rand_state = 32'h01ac_3b3a;

   int error_count  = 0;
   int check_count  = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int errors_at_test_start = 0;

   // Reference taps per lane
   int model_fine   [NUM_LANES];
   int model_coarse [NUM_LANES];
   bit model_uf     [NUM_LANES];

   tb_clk_gen #(
      .PERIOD_NS (CLK_NS)
   ) tb_clk_gen_i (
      .clk (clk)
   );

   ctl_delay_top ctl_delay_top_i (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .dec_taps      (dec_taps),
      .coarse_inc    (coarse_inc),
      .rd_lane       (rd_lane),
      .lane_cnt      (lane_cnt),
      .done          (done),
      .rd_fine       (rd_fine),
      .rd_coarse     (rd_coarse),
      .rd_underflow  (rd_underflow),
      .any_underflow (any_underflow)
   );

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // Upper bits of the LCG, low bits repeat too quickly
   function automatic int rand_below(input int n);
      return int'(next_random() >> 8) % n;
   endfunction

   task automatic check_value(input int actual, input int expected, input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("MISMATCH at %0t ns: %s, got %0d, expected %0d",
                  $time, what, actual, expected);
      end
   endtask

   task automatic begin_test();
      errors_at_test_start = error_count;
   endtask

   task automatic end_test(input int num, input string name);
      if (error_count == errors_at_test_start) begin
         tests_passed++;
         $display("Test %0d (%s): pass", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d (%s): FAIL, %0d errors", num, name,
                  error_count - errors_at_test_start);
      end
   endtask

   // Lanes below lanes_done took the full decrement run
   task automatic model_apply(input int dec, input int cinc, input int lanes_done);
      for (int l = 0; l < lanes_done; l++) begin
         if (dec > model_fine[l]) begin
            model_uf[l]   = 1'b1;
            model_fine[l] = 0;
         end else begin
            model_fine[l] = model_fine[l] - dec;
         end
         model_coarse[l] = (model_coarse[l] + cinc) % COARSE_MOD;
      end
   endtask

   task automatic check_all_lanes(input string tag);
      int any_uf;
      any_uf = 0;
      for (int l = 0; l < NUM_LANES; l++) begin
         @(posedge clk);
         rd_lane <= lane_idx_t'(l);
         @(negedge clk);
         check_value(int'(rd_fine), model_fine[l],
                     $sformatf("lane %0d fine tap %s", l, tag));
         check_value(int'(rd_coarse), model_coarse[l],
                     $sformatf("lane %0d coarse tap %s", l, tag));
         check_value(int'(rd_underflow), int'(model_uf[l]),
                     $sformatf("lane %0d underflow flag %s", l, tag));
         if (model_uf[l]) begin
            any_uf = 1;
         end
      end
      check_value(int'(any_underflow), any_uf, $sformatf("any_underflow %s", tag));
   endtask

   task automatic launch(input int dec, input int cinc);
      @(posedge clk);
      dec_taps   <= fine_tap_t'(dec);
      coarse_inc <= (cinc != 0);
      start      <= 1'b1;
   endtask

   // Lane order is watched on every cycle of the run
   task automatic wait_done(output bit ok);
      int cycles;
      int prev_lane;
      cycles    = 0;
      prev_lane = 0;
      ok        = 1'b0;
      while (!ok && cycles < RUN_CYCLES + 40) begin
         @(negedge clk);
         cycles++;
         if (cycles <= 2) begin
            check_value(int'(lane_cnt), 0, "lane_cnt at start of run");
         end
         if (int'(lane_cnt) < prev_lane) begin
            check_value(int'(lane_cnt), prev_lane, "lane_cnt went backwards");
         end
         if (int'(lane_cnt) > NUM_LANES - 1) begin
            check_value(int'(lane_cnt), NUM_LANES - 1, "lane_cnt past last lane");
         end
         prev_lane = int'(lane_cnt);
         if (done) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         error_count++;
         $display("Timed out after %0d cycles waiting for done to rise", cycles);
      end
   endtask

   task automatic release_start(input int hold);
      repeat (hold) begin
         @(negedge clk);
         check_value(int'(done), 1, "done while start held high");
      end
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_value(int'(done), 1, "done in the cycle start falls");
      @(negedge clk);
      check_value(int'(done), 0, "done one cycle after start fell");
      check_value(int'(lane_cnt), 0, "lane_cnt after start fell");
   endtask

   task automatic full_run(input int dec, input int cinc, input int hold);
      bit ok;
      launch(dec, cinc);
      wait_done(ok);
      if (ok) begin
         release_start(hold);
      end else begin
         @(posedge clk);
         start <= 1'b0;
         repeat (2) @(negedge clk);
      end
      model_apply(dec, cinc, NUM_LANES);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("Watchdog expired, the tests did not finish within %0d cycles",
               WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int dec;
      int stop_lane;
      int cycles;
      bit seen;

      rst        = 1'b1;
      start      = 1'b0;
      dec_taps   = '0;
      coarse_inc = 1'b0;
      rd_lane    = '0;
      for (int l = 0; l < NUM_LANES; l++) begin
         model_fine[l]   = `FINE_TAP_INIT;
         model_coarse[l] = 0;
         model_uf[l]     = 1'b0;
      end

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      begin_test();
      repeat (2) @(negedge clk);
      check_value(int'(done), 0, "done after reset");
      check_value(int'(any_underflow), 0, "any_underflow after reset");
      check_all_lanes("after reset");
      end_test(1, "reset values");

      begin_test();
      full_run(rand_below(8), 0, 1 + rand_below(4));
      check_all_lanes("after fine-only run");
      end_test(2, "fine-only run");

      begin_test();
      full_run(rand_below(8), 1, 1 + rand_below(4));
      check_all_lanes("after coarse run");
      end_test(3, "coarse increment run");

      // Each run takes at least 8 taps, so underflow is reached
      begin_test();
      for (int r = 0; r < 6; r++) begin
         full_run(8 + rand_below(16), rand_below(2), 1 + rand_below(4));
         check_all_lanes($sformatf("after repeated run %0d", r));
      end
      check_value(int'(any_underflow), 1, "any_underflow after repeated runs");
      end_test(4, "accumulating runs");

      begin_test();
      full_run(rand_below(64), 1, 6);
      check_all_lanes("after long run");
      end_test(5, "lane order and done");

      // Drop start as a new lane is entered, before its first strobe
      begin_test();
      dec       = 1 + rand_below(15);
      stop_lane = 1 + rand_below(NUM_LANES - 1);
      launch(dec, 1);
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < RUN_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (int'(lane_cnt) == stop_lane) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         error_count++;
         $display("Lane %0d was never reached during the aborted run", stop_lane);
      end
      @(posedge clk);
      start <= 1'b0;
      repeat (2) @(negedge clk);
      check_value(int'(done), 0, "done after aborted run");
      check_value(int'(lane_cnt), 0, "lane_cnt after aborted run");
      model_apply(dec, 1, stop_lane);
      check_all_lanes("after aborted run");
      full_run(1 + rand_below(15), 1, 2);
      check_all_lanes("after restarted run");
      end_test(6, "abort and restart");

      $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
               tests_passed, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/ctl_delay_pkg.sv
hdl/ctl_lane_delay_seq.sv
hdl/phaser_out_lane.sv
hdl/lane_tap_status.sv
hdl/ctl_delay_top.sv
test/tb_clk_gen.sv
test/ctl_delay_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module ctl_delay_tb -f files.f -o ctl_delay_sim \
   > build.log 2>&1 \
   && ./obj_dir/ctl_delay_sim > sim.log 2>&1 \
   || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
